//--- hdl/lsu_isa_pkg.sv
// instruction set definitions for the load/store unit
// operation codes, functional unit select, exception causes
// and the width constants of the 64-bit datapath

package lsu_isa_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    parameter int unsigned XLEN    = 64;
    parameter int unsigned BE_W    = XLEN / 8;
    // lowest address bit that must match all bits above it
    parameter int unsigned VA_BITS = 39;

    // ----------------------------------------------------------------------
    // operations
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        LD  = 4'd0,
        LW  = 4'd1,
        LWU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LB  = 4'd5,
        LBU = 4'd6,
        SD  = 4'd7,
        SW  = 4'd8,
        SH  = 4'd9,
        SB  = 4'd10
    } lsu_op_e;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } fu_e;

    // standard RISC-V cause numbers
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        ST_ADDR_MISALIGNED = 4'd6,
        LOAD_PAGE_FAULT    = 4'd13,
        STORE_PAGE_FAULT   = 4'd15
    } exc_cause_e;

endpackage

//--- hdl/lsu_ctrl_pkg.sv
// structs passed between the load/store unit blocks
// exception record, incoming request, buffered control entry
// and the result returned per operation

package lsu_ctrl_pkg;
    import lsu_isa_pkg::*;

    // default transaction id width, the top level must agree
    parameter int unsigned TRANS_ID_W = 3;

    typedef struct packed {
        exc_cause_e      cause;
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception_t;

    typedef struct packed {
        lsu_op_e               op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       imm;
        // store data
        logic [XLEN-1:0]       operand_b;
        logic [TRANS_ID_W-1:0] trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       vaddr;
        logic [XLEN-1:0]       wdata;
        logic [BE_W-1:0]       be;
        fu_e                   fu;
        lsu_op_e               op;
        logic [TRANS_ID_W-1:0] trans_id;
        exception_t            exception;
    } lsu_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN-1:0]       data;
        exception_t            exception;
    } lsu_result_t;

endpackage

//--- hdl/lsu_agu.sv
// address generation for the load/store unit
// virtual address, byte enables and store lane alignment
// misaligned and non-canonical address detection

`timescale 1ns/1ps

module lsu_agu
    import lsu_isa_pkg::*;
    import lsu_ctrl_pkg::*;
(
    input  logic      valid_i,
    input  lsu_req_t  req_i,
    output lsu_ctrl_t ctrl_o
);

    logic [XLEN-1:0] vaddr;
    logic [BE_W-1:0] size_mask;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
    logic            misaligned;
    logic            non_canonical;
    fu_e             fu;
    exception_t      ex;

    // signed add, immediate is already sign extended
    assign vaddr = $unsigned($signed(req_i.imm) + $signed(req_i.operand_a));

    assign fu = (req_i.op inside {SD, SW, SH, SB}) ? STORE : LOAD;

    // ----------------------------------------------------------------------
    // access size
    // ----------------------------------------------------------------------
    always_comb begin : size_decode
        size_mask  = '0;
        misaligned = 1'b0;
        case (req_i.op)
            LD, SD: begin
                size_mask  = 8'b1111_1111;
                misaligned = |vaddr[2:0];
            end
            LW, LWU, SW: begin
                size_mask  = 8'b0000_1111;
                misaligned = |vaddr[1:0];
            end
            LH, LHU, SH: begin
                size_mask  = 8'b0000_0011;
                misaligned = vaddr[0];
            end
            // bytes are always aligned
            LB, LBU, SB: begin
                size_mask  = 8'b0000_0001;
            end
            default: ;
        endcase
    end

    // byte lanes follow the offset inside the doubleword
    assign be    = size_mask << vaddr[2:0];
    assign wdata = req_i.operand_b << {vaddr[2:0], 3'b000};

    // upper bits must all be copies of bit VA_BITS
    assign non_canonical = !((&vaddr[XLEN-1:VA_BITS]) || !(|vaddr[XLEN-1:VA_BITS]));

    // ----------------------------------------------------------------------
    // exception
    // ----------------------------------------------------------------------
    always_comb begin : exception_gen
        ex = '0;
        // page fault takes priority over misalignment
        if (non_canonical) begin
            ex.valid = 1'b1;
            ex.tval  = vaddr;
            if (fu == STORE) begin
                ex.cause = STORE_PAGE_FAULT;
            end else begin
                ex.cause = LOAD_PAGE_FAULT;
            end
        end else if (misaligned) begin
            ex.valid = 1'b1;
            ex.tval  = vaddr;
            if (fu == STORE) begin
                ex.cause = ST_ADDR_MISALIGNED;
            end else begin
                ex.cause = LD_ADDR_MISALIGNED;
            end
        end
    end

    assign ctrl_o = '{
        valid:     valid_i,
        vaddr:     vaddr,
        wdata:     wdata,
        be:        be,
        fu:        fu,
        op:        req_i.op,
        trans_id:  req_i.trans_id,
        exception: ex
    };

endmodule

//--- hdl/lsu_bypass.sv
// two-entry control buffer between address generation and execution
// passes the request straight through while empty

`timescale 1ns/1ps

module lsu_bypass
    import lsu_ctrl_pkg::*;
#(
    parameter type payload_t = lsu_ctrl_t
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     ready_o
);

    payload_t   mem_q [2];
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic       empty;
    logic       push;
    logic       pop_head;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // head entry, or the incoming request when nothing is queued
    assign data_o = empty ? data_i : mem_q[rd_ptr_q];

    // accepted request that the consumer did not take right away
    assign push     = data_i.valid & empty & ~pop_i;
    assign pop_head = pop_i & ~empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop_head) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop_head};
        end
    end

    always_ff @(posedge clk_i) begin : entry_store
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
        // drop the valid flag of the entry just taken
        if (pop_head) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

endmodule

//--- hdl/lsu_mem_unit.sv
// execution side of the load/store unit
// local doubleword memory, byte-masked stores, extended loads
// one registered result per popped operation

`timescale 1ns/1ps

module lsu_mem_unit
    import lsu_isa_pkg::*;
    import lsu_ctrl_pkg::*;
#(
    parameter int unsigned MEM_DEPTH  = 16,
    parameter int unsigned TRANS_ID_W = 3
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  lsu_ctrl_t   ctrl_i,
    output logic        pop_o,
    output lsu_result_t result_o
);

    localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

    logic [XLEN-1:0]       mem_q [MEM_DEPTH];
    logic [IDX_W-1:0]      idx;
    logic                  busy_q;
    lsu_result_t           result_q;

    // second cycle of a load
    logic [XLEN-1:0]       ld_data_q;
    logic [2:0]            ld_off_q;
    lsu_op_e               ld_op_q;
    logic [TRANS_ID_W-1:0] ld_tid_q;
    logic [XLEN-1:0]       ld_shifted;
    logic [XLEN-1:0]       ld_result;

    // address bits above the index are ignored, so accesses wrap
    assign idx   = ctrl_i.vaddr[3 +: IDX_W];
    assign pop_o = ctrl_i.valid & ~busy_q;

    // ----------------------------------------------------------------------
    // load alignment and extension
    // ----------------------------------------------------------------------
    always_comb begin : load_extend
        ld_shifted = ld_data_q >> {ld_off_q, 3'b000};
        case (ld_op_q)
            LD:      ld_result = ld_shifted;
            LW:      ld_result = {{32{ld_shifted[31]}}, ld_shifted[31:0]};
            LWU:     ld_result = {32'b0, ld_shifted[31:0]};
            LH:      ld_result = {{48{ld_shifted[15]}}, ld_shifted[15:0]};
            LHU:     ld_result = {48'b0, ld_shifted[15:0]};
            LB:      ld_result = {{56{ld_shifted[7]}}, ld_shifted[7:0]};
            LBU:     ld_result = {56'b0, ld_shifted[7:0]};
            default: ld_result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // memory and result
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : exec
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            result_q <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            result_q.valid <= 1'b0;
            busy_q         <= 1'b0;
            if (busy_q) begin
                result_q <= '{valid: 1'b1, trans_id: ld_tid_q, data: ld_result,
                              exception: '0};
            end else if (pop_o) begin
                if (ctrl_i.exception.valid) begin
                    // no memory access on exception
                    result_q <= '{valid: 1'b1, trans_id: ctrl_i.trans_id, data: '0,
                                  exception: ctrl_i.exception};
                end else if (ctrl_i.fu == STORE) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (ctrl_i.be[b]) begin
                            mem_q[idx][8*b +: 8] <= ctrl_i.wdata[8*b +: 8];
                        end
                    end
                    result_q <= '{valid: 1'b1, trans_id: ctrl_i.trans_id, data: '0,
                                  exception: '0};
                end else begin
                    busy_q <= 1'b1;
                end
            end
        end
    end

    // registered read, finished in the busy cycle
    always_ff @(posedge clk_i) begin : load_capture
        if (pop_o) begin
            ld_data_q <= mem_q[idx];
            ld_off_q  <= ctrl_i.vaddr[2:0];
            ld_op_q   <= ctrl_i.op;
            ld_tid_q  <= ctrl_i.trans_id;
        end
    end

    assign result_o = result_q;

endmodule

//--- hdl/lsu_top.sv
// load/store unit top level
// address generation, control buffer and memory execution unit

`timescale 1ns/1ps

module lsu_top
    import lsu_ctrl_pkg::*;
#(
    parameter int unsigned TRANS_ID_W = 3,
    parameter int unsigned MEM_DEPTH  = 16
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        valid_i,
    input  lsu_req_t    req_i,
    output logic        ready_o,
    output lsu_result_t result_o
);

    lsu_ctrl_t agu_ctrl;
    lsu_ctrl_t exe_ctrl;
    logic      exe_pop;

    // struct fields are sized by the package width
    if (TRANS_ID_W != lsu_ctrl_pkg::TRANS_ID_W) begin : g_trans_id_check
        $error("TRANS_ID_W differs from the lsu_ctrl_pkg width");
    end

    lsu_agu lsu_agu_i (
        .valid_i ( valid_i  ),
        .req_i   ( req_i    ),
        .ctrl_o  ( agu_ctrl )
    );

    lsu_bypass #(
        .payload_t ( lsu_ctrl_t )
    ) lsu_bypass_i (
        .clk_i   ( clk_i    ),
        .rst_ni  ( rst_ni   ),
        .data_i  ( agu_ctrl ),
        .pop_i   ( exe_pop  ),
        .data_o  ( exe_ctrl ),
        .ready_o ( ready_o  )
    );

    lsu_mem_unit #(
        .MEM_DEPTH  ( MEM_DEPTH  ),
        .TRANS_ID_W ( TRANS_ID_W )
    ) lsu_mem_unit_i (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .ctrl_i   ( exe_ctrl ),
        .pop_o    ( exe_pop  ),
        .result_o ( result_o )
    );

endmodule

//--- verif/lsu_props.sv
// concurrent checks on the control buffer
// occupancy tracked from the buffer handshake
// fill count limit, ready against empty, pop only with valid data

`timescale 1ns/1ps

module lsu_props
    import lsu_ctrl_pkg::*;
(
    input logic       clk_i,
    input logic       rst_ni,
    input logic [1:0] cnt_i,
    input logic       ready_i,
    input logic       pop_i,
    input lsu_ctrl_t  in_data_i,
    input lsu_ctrl_t  data_i
);

    logic [1:0] occ_q;
    logic       accept;

    // entries held, counted from accepts and pops at the buffer ports
    assign accept = in_data_i.valid & ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : occ_track
        if (!rst_ni) begin
            occ_q <= 2'd0;
        end else begin
            occ_q <= occ_q + {1'b0, accept} - {1'b0, pop_i};
        end
    end

    count_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (occ_q <= 2'd2) && (cnt_i == occ_q))
        else $error("control buffer fill count is wrong or above two");

    // request side is open only while nothing is queued
    ready_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_i == (occ_q == 2'd0))
        else $error("ready does not match the empty buffer state");

    pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> data_i.valid)
        else $error("buffer popped while its output was not valid");

endmodule

bind lsu_bypass lsu_props lsu_props_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .cnt_i     ( cnt_q   ),
    .ready_i   ( ready_o ),
    .pop_i     ( pop_i   ),
    .in_data_i ( data_i  ),
    .data_i    ( data_o  )
);

//--- verif/lsu_tb_checker.sv
// scoreboard for the load/store unit
// reference model with its own memory, expected result queue
// and the compare process on result_o

`timescale 1ns/1ps

module lsu_tb_checker
    import lsu_isa_pkg::*;
    import lsu_ctrl_pkg::*;
#(
    parameter int unsigned MEM_DEPTH = 16
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        valid_i,
    input  logic        ready_i,
    input  lsu_req_t    req_i,
    input  lsu_result_t result_i,
    output int          pending_o,
    output int          check_count_o,
    output int          error_count_o,
    output int          stall_count_o
);

    localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

    logic [XLEN-1:0] model_mem [MEM_DEPTH];
    lsu_result_t     exp_q [$];

    function automatic int op_bytes(lsu_op_e op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // reference model that also applies stores to the model memory
    // ----------------------------------------------------------------------
    function automatic lsu_result_t predict(lsu_req_t req);
        lsu_result_t             res;
        logic [XLEN-1:0]         addr;
        logic [XLEN-VA_BITS-1:0] upper;
        logic                    store;
        int                      nbytes;
        int                      off;
        int                      idx;
        int                      k;
        res            = '0;
        res.valid      = 1'b1;
        res.trans_id   = req.trans_id;
        addr           = req.operand_a + req.imm;
        upper          = addr[XLEN-1:VA_BITS];
        store          = req.op inside {SD, SW, SH, SB};
        nbytes         = op_bytes(req.op);
        off            = int'(addr[2:0]);
        idx            = int'(addr[3 +: IDX_W]);
        if (upper != '0 && upper != '1) begin
            res.exception.valid = 1'b1;
            res.exception.tval  = addr;
            res.exception.cause = store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        end else if ((off % nbytes) != 0) begin
            res.exception.valid = 1'b1;
            res.exception.tval  = addr;
            res.exception.cause = store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
        end else if (store) begin
            for (k = 0; k < nbytes; k++) begin
                model_mem[idx][8*(off+k) +: 8] = req.operand_b[8*k +: 8];
            end
        end else begin
            for (k = 0; k < nbytes; k++) begin
                res.data[8*k +: 8] = model_mem[idx][8*(off+k) +: 8];
            end
            // signed loads copy the top bit of the loaded value upward
            if ((req.op inside {LW, LH, LB}) && res.data[8*nbytes-1]) begin
                for (k = nbytes; k < 8; k++) begin
                    res.data[8*k +: 8] = 8'hff;
                end
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // compare on the falling edge where all signals are settled
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin : compare
        lsu_result_t want;
        if (!rst_ni) begin
            foreach (model_mem[i]) begin
                model_mem[i] = '0;
            end
            exp_q.delete();
            check_count_o = 0;
            error_count_o = 0;
            stall_count_o = 0;
        end else begin
            if (result_i.valid) begin
                check_count_o++;
                if (exp_q.size() == 0) begin
                    error_count_o++;
                    $display("result with trans_id %0d arrived with no request outstanding",
                             result_i.trans_id);
                end else begin
                    want = exp_q.pop_front();
                    if (result_i !== want) begin
                        error_count_o++;
                        $display({"FAILED at %0t: trans_id %0d data %h exc %0b cause %0d ",
                                  "tval %h, expected trans_id %0d data %h exc %0b cause %0d ",
                                  "tval %h"},
                                 $time, result_i.trans_id, result_i.data,
                                 result_i.exception.valid, result_i.exception.cause,
                                 result_i.exception.tval, want.trans_id, want.data,
                                 want.exception.valid, want.exception.cause,
                                 want.exception.tval);
                    end
                end
            end
            // request held back by a busy execution side
            if (valid_i && !ready_i) begin
                stall_count_o++;
            end
            // accepted at the coming rising edge
            if (valid_i && ready_i) begin
                exp_q.push_back(predict(req_i));
            end
        end
        pending_o = exp_q.size();
    end

endmodule

//--- verif/lsu_tb.sv
// load/store unit testbench top
// clock, reset, directed and LFSR driven requests, DUT instance
// scoreboard instance and the final report

`timescale 1ns/1ps

module lsu_tb
    import lsu_isa_pkg::*;
    import lsu_ctrl_pkg::*;
();

    localparam int unsigned MEM_DEPTH      = 16;
    localparam int          ACCEPT_TIMEOUT = 20;
    localparam int          DRAIN_TIMEOUT  = 100;
    localparam int          RANDOM_OPS     = 120;

    logic        clk_i;
    logic        rst_ni;
    logic        valid_i;
    lsu_req_t    req_i;
    logic        ready_o;
    lsu_result_t result_o;

    logic [31:0]           lfsr_q;
    logic [TRANS_ID_W-1:0] next_tid;
    logic                  abort;
    int                    tb_errors;
    int                    pending;
    int                    check_count;
    int                    error_count;
    int                    stall_count;

    always #5 clk_i = ~clk_i;

    lsu_top #(
        .TRANS_ID_W ( TRANS_ID_W ),
        .MEM_DEPTH  ( MEM_DEPTH  )
    ) lsu_top_i (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .valid_i  ( valid_i  ),
        .req_i    ( req_i    ),
        .ready_o  ( ready_o  ),
        .result_o ( result_o )
    );

    lsu_tb_checker #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) scoreboard_i (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .valid_i       ( valid_i     ),
        .ready_i       ( ready_o     ),
        .req_i         ( req_i       ),
        .result_i      ( result_o    ),
        .pending_o     ( pending     ),
        .check_count_o ( check_count ),
        .error_count_o ( error_count ),
        .stall_count_o ( stall_count )
    );

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    // galois lfsr stepped once per bit handed out
    function automatic logic [63:0] next_bits(int n);
        logic [63:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            bits   = {bits[62:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    // holds the request until it is taken and leaves valid high
    task automatic issue(input lsu_op_e op, input logic [63:0] base,
                         input logic [63:0] imm, input logic [63:0] data);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (!abort) begin
            valid_i         = 1'b1;
            req_i.op        = op;
            req_i.operand_a = base;
            req_i.imm       = imm;
            req_i.operand_b = data;
            req_i.trans_id  = next_tid;
            next_tid        = next_tid + 1'b1;
            while (!taken && waited < ACCEPT_TIMEOUT) begin
                @(negedge clk_i);
                taken = ready_o;
                @(posedge clk_i);
                #1;
                waited++;
            end
            if (!taken) begin
                abort = 1'b1;
                tb_errors++;
                $display("timeout: request with trans_id %0d was never accepted",
                         req_i.trans_id);
            end
        end
    endtask

    task automatic access(input lsu_op_e op, input logic [63:0] addr, input logic [63:0] data);
        issue(op, addr, 64'd0, data);
    endtask

    task automatic idle(input int n);
        valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic random_op();
        logic [3:0]  code;
        logic [2:0]  off;
        logic [63:0] addr;
        logic [63:0] r5;
        logic [63:0] imm;
        lsu_op_e     op;
        code = 4'(next_bits(4) % 64'd11);
        op   = lsu_op_e'(code);
        // index bits plus a few ignored bits above them
        addr = next_bits(8) << 3;
        off  = 3'(next_bits(3));
        // left misaligned now and then
        if (next_bits(3) != 0) begin
            case (op)
                LD, SD:      off = 3'b000;
                LW, LWU, SW: off = off & 3'b100;
                LH, LHU, SH: off = off & 3'b110;
                default:     ;
            endcase
        end
        addr[2:0] = off;
        if (next_bits(4) == 0) begin
            addr[50] = 1'b1;
        end
        r5  = next_bits(5);
        imm = {{59{r5[4]}}, r5[4:0]};
        issue(op, addr - imm, imm, next_bits(64));
        if (next_bits(2) == 0) begin
            idle(1);
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int i;
        int waited;
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        valid_i   = 1'b0;
        req_i     = '0;
        lfsr_q    = 32'h17ee_f0bf;
        next_tid  = '0;
        abort     = 1'b0;
        tb_errors = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // fresh memory reads zero everywhere
        for (i = 0; i < MEM_DEPTH; i++) begin
            access(LD, 64'(i * 8), '0);
        end

        // every load size on one stored doubleword
        access(SD, 64'h10, 64'hf1e2_d3c4_b5a6_9788);
        access(LD, 64'h10, '0);
        access(LW, 64'h10, '0);
        access(LW, 64'h14, '0);
        access(LWU, 64'h14, '0);
        access(LH, 64'h16, '0);
        access(LHU, 64'h12, '0);
        access(LB, 64'h17, '0);
        access(LBU, 64'h11, '0);
        access(SW, 64'h18, 64'h0000_0000_9abc_def0);
        access(SH, 64'h1e, 64'h0000_0000_0000_8001);
        access(SB, 64'h1d, 64'h0000_0000_0000_00c3);
        access(LW, 64'h18, '0);
        access(LWU, 64'h18, '0);
        access(LH, 64'h1e, '0);
        access(LHU, 64'h1e, '0);
        access(LB, 64'h1d, '0);
        access(LBU, 64'h1d, '0);
        access(LD, 64'h18, '0);

        // misaligned accesses leave memory untouched
        access(SD, 64'h20, 64'h0123_4567_89ab_cdef);
        access(LW, 64'h22, '0);
        access(SD, 64'h24, 64'hdead_beef_dead_beef);
        access(SH, 64'h21, 64'hffff);
        access(LHU, 64'h23, '0);
        access(LD, 64'h20, '0);

        // non-canonical addresses and a canonical high address that wraps
        access(LD, 64'h0000_0080_0000_0010, '0);
        access(SW, 64'hffff_ff7f_ffff_fff2, 64'h1);
        access(LH, 64'h0100_0000_0000_0021, '0);
        access(LD, 64'hffff_ff80_0000_0020, '0);

        // partial stores merging into one doubleword
        access(SD, 64'h28, '0);
        access(SB, 64'h29, 64'haa);
        // 0x42 minus 24 lands on 0x2a
        issue(SH, 64'h42, ~64'd23, 64'hbbcc);
        access(SW, 64'h2c, 64'h1122_3344);
        access(SB, 64'h28, 64'h5a);
        access(LD, 64'h28, '0);
        idle(2);

        for (i = 0; i < RANDOM_OPS; i++) begin
            random_op();
        end
        idle(1);

        waited = 0;
        while (!abort && pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("%0d expected results never arrived", pending);
        end
        // room for any stray result to show up
        repeat (4) @(posedge clk_i);

        if (stall_count == 0) begin
            tb_errors++;
            $display("ready_o never fell while a request was waiting");
        end

        $display("results checked %0d, mismatches %0d, stalled cycles %0d, other errors %0d",
                 check_count, error_count, stall_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- lsu_top.f
hdl/lsu_isa_pkg.sv
hdl/lsu_ctrl_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_bypass.sv
hdl/lsu_mem_unit.sv
hdl/lsu_top.sv
verif/lsu_props.sv
verif/lsu_tb_checker.sv
verif/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -sv --assert --top-module lsu_tb -f lsu_top.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
    exit 1
fi
exit 0
